/* logic/bbc_cfg.svh */
`ifndef BBC_CFG_SVH
`define BBC_CFG_SVH

// Bus widths
`define BBC_ADDR_W 16
`define BBC_DATA_W 8
`define BBC_DISP_W 15

// Status byte for the absent serial ACIA, transmit data register empty
`define BBC_ACIA_IDLE 8'h02

// SHEILA page and register bases within it
`define BBC_SHEILA_PAGE  8'hFE
`define BBC_SH_CRTC      8'h00
`define BBC_SH_ACIA      8'h08
`define BBC_SH_ADC_M     8'h18
`define BBC_SH_FDCON     8'h24
`define BBC_SH_FDC       8'h28
`define BBC_SH_ROMSEL    8'h30
`define BBC_SH_ACCCON    8'h34
`define BBC_SH_SYS_VIA   8'h40
`define BBC_SH_USER_VIA  8'h60
`define BBC_SH_ADC_B     8'hC0

// High nibble adjustment when the screen wraps past 8000
`define BBC_WRAP_MODE3   4'd8
`define BBC_WRAP_MODE6   4'd12
`define BBC_WRAP_MODE012 4'd6
`define BBC_WRAP_MODE45  4'd11

`endif

/* logic/bbc_pkg.sv */
`default_nettype none

`include "bbc_cfg.svh"

package bbc_pkg;

	typedef enum logic {
		MODEL_B,
		MODEL_MASTER
	} model_e;

	// One region per CPU cycle
	typedef enum logic [3:0] {
		REG_NONE,
		REG_RAM,
		REG_ROM,
		REG_MOS,
		REG_CRTC,
		REG_ACIA,
		REG_FDCON,
		REG_FDC,
		REG_ADC,
		REG_ROMSEL,
		REG_ACCCON,
		REG_SYS_VIA,
		REG_USER_VIA
	} region_e;

	// CPU side of the bus, including the clock enable and PHI0
	typedef struct packed {
		logic [`BBC_ADDR_W-1:0] addr;
		logic [`BBC_DATA_W-1:0] dout;
		logic                   r_nw;
		logic                   sync;
		logic                   clken;
		logic                   phi0;
	} cpu_bus_t;

	// Read bytes and interrupt lines from the external peripherals
	typedef struct packed {
		logic [`BBC_DATA_W-1:0] crtc_do;
		logic [`BBC_DATA_W-1:0] sys_via_do;
		logic [`BBC_DATA_W-1:0] user_via_do;
		logic [`BBC_DATA_W-1:0] adc_do;
		logic [`BBC_DATA_W-1:0] fdc_do;
		logic                   sys_via_irq;
		logic                   user_via_irq;
		logic                   fdc_irq;
		logic                   fdc_drq;
	} periph_rd_t;

	typedef struct packed {
		logic [13:0] ma;
		logic [4:0]  ra;
	} crtc_addr_t;

	typedef struct packed {
		logic [`BBC_ADDR_W-1:0] adr;
		logic                   we;
		logic [`BBC_DATA_W-1:0] dout;
	} mem_port_t;

	// Bit 7 down to bit 0 of the addressable latch
	typedef struct packed {
		logic       shift_lock_led_n;
		logic       caps_lock_led_n;
		logic [1:0] disp_offs;
		logic       keyb_enable_n;
		logic       speech_rd_n;
		logic       speech_wr_n;
		logic       sound_enable_n;
	} ic32_t;

	typedef struct packed {
		logic irr;
		logic tst;
		logic ifj;
		logic itu;
		logic y;
		logic x;
		logic e;
		logic d;
	} acccon_t;

	typedef struct packed {
		logic [3:0] drive;
		logic       side;
		logic       reset;
		logic       density;
	} floppy_ctl_t;

endpackage

`default_nettype wire

/* logic/sheila_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bbc_cfg.svh"

module sheila_decode (
	input  wire [`BBC_ADDR_W-1:0] addr_i,
	input  wire bbc_pkg::model_e  model_i,
	output bbc_pkg::region_e      region_o
);
	import bbc_pkg::*;

	logic [7:0] page;
	logic [7:0] offs;
	logic       master;
	region_e    sheila;

	assign page   = addr_i[15:8];
	assign offs   = addr_i[7:0];
	assign master = (model_i == MODEL_MASTER);

	// Register selects inside FE00-FEFF
	always_comb begin
		sheila = REG_NONE;
		if ((offs & 8'hF8) == `BBC_SH_CRTC) begin
			sheila = REG_CRTC;
		end else if ((offs & 8'hF8) == `BBC_SH_ACIA) begin
			sheila = REG_ACIA;
		end else if (master && (offs & 8'hF8) == `BBC_SH_ADC_M) begin
			sheila = REG_ADC;
		end else if (master && (offs & 8'hFC) == `BBC_SH_FDCON) begin
			sheila = REG_FDCON;
		end else if (master && (offs & 8'hF8) == `BBC_SH_FDC) begin
			sheila = REG_FDC;
		end else if ((offs & 8'hFC) == `BBC_SH_ROMSEL) begin
			sheila = REG_ROMSEL;
		end else if (master && (offs & 8'hFC) == `BBC_SH_ACCCON) begin
			sheila = REG_ACCCON;
		end else if ((offs & 8'hE0) == `BBC_SH_SYS_VIA) begin
			sheila = REG_SYS_VIA;
		end else if ((offs & 8'hE0) == `BBC_SH_USER_VIA) begin
			sheila = REG_USER_VIA;
		end else if (!master && (offs & 8'hE0) == `BBC_SH_ADC_B) begin
			sheila = REG_ADC;
		end
	end

	always_comb begin
		if (!addr_i[15]) begin
			region_o = REG_RAM;
		end else if (!addr_i[14]) begin
			region_o = REG_ROM;
		end else if (page == `BBC_SHEILA_PAGE) begin
			region_o = sheila;
		end else if (page[7:1] == 7'b1111_110) begin
			// FRED and JIM, nothing fitted
			region_o = REG_NONE;
		end else begin
			region_o = REG_MOS;
		end
	end

endmodule

`default_nettype wire

/* logic/system_latches.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bbc_cfg.svh"

module system_latches (
	input  wire                    CLK48M_I,
	input  wire                    reset_n,
	input  wire bbc_pkg::cpu_bus_t bus_i,
	input  wire bbc_pkg::region_e  region_i,
	input  wire bbc_pkg::model_e   model_i,
	input  wire [7:0]              sys_via_pb_i,
	output logic [`BBC_DATA_W-1:0] romsel_o,
	output bbc_pkg::ic32_t         ic32_o
);
	import bbc_pkg::*;

	logic [7:0] ic32_q;
	logic       romsel_we;
	logic       master;

	assign master    = (model_i == MODEL_MASTER);
	assign romsel_we = !bus_i.r_nw && (region_i == REG_ROMSEL);

	// PB2..0 pick the latch bit, PB3 is the value written into it
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			ic32_q <= '0;
		end else if (bus_i.clken) begin
			ic32_q[sys_via_pb_i[2:0]] <= sys_via_pb_i[3];
		end
	end

	assign ic32_o = ic32_t'(ic32_q);

	// Paged ROM select at FE30
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			romsel_o <= '0;
		end else if (bus_i.clken && romsel_we) begin
			// Model B has no RAM paging bit
			romsel_o <= {bus_i.dout[7] & master, bus_i.dout[6:0]};
		end
	end

endmodule

`default_nettype wire

/* logic/master_control_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module master_control_regs (
	input  wire                    CLK48M_I,
	input  wire                    reset_n,
	input  wire bbc_pkg::cpu_bus_t bus_i,
	input  wire bbc_pkg::region_e  region_i,
	output bbc_pkg::acccon_t       acccon_o,
	output logic                   shadow_ram_o,
	output bbc_pkg::floppy_ctl_t   floppy_o
);
	import bbc_pkg::*;

	logic vdu_op;
	logic acccon_we;
	logic fdcon_we;
	logic in_shadow;

	assign acccon_we = !bus_i.r_nw && (region_i == REG_ACCCON);
	assign fdcon_we  = !bus_i.r_nw && (region_i == REG_FDCON);

	// Access control at FE34 and VDU driver tracking
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			acccon_o <= '0;
			vdu_op   <= 1'b0;
		end else if (bus_i.clken) begin
			if (acccon_we) begin
				acccon_o <= acccon_t'(bus_i.dout);
			end
			// Last opcode fetched from C000-DFFF
			if (bus_i.sync) begin
				vdu_op <= (bus_i.addr[15:13] == 3'b110);
			end
		end
	end

	// Screen memory lives at 3000-7FFF
	assign in_shadow = (bus_i.addr[15:12] == 4'h3) || (bus_i.addr[15:14] == 2'b01);

	// VDU code sees shadow RAM only on data cycles, never on its own fetch
	assign shadow_ram_o = in_shadow &&
		(acccon_o.x || (acccon_o.e && vdu_op && !bus_i.sync));

	// Drive control at FE24
	always_ff @(posedge CLK48M_I) begin
		if (!reset_n) begin
			floppy_o.drive   <= 4'b1111;
			floppy_o.side    <= 1'b0;
			floppy_o.reset   <= 1'b0;
			floppy_o.density <= 1'b0;
		end else if (bus_i.clken && fdcon_we) begin
			// Only drive 0 and 1 selectable, active low
			floppy_o.drive   <= {3'b111, ~bus_i.dout[0]};
			floppy_o.reset   <= bus_i.dout[2];
			floppy_o.side    <= ~bus_i.dout[4];
			floppy_o.density <= bus_i.dout[5];
		end
	end

endmodule

`default_nettype wire

/* logic/screen_address.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bbc_cfg.svh"

module screen_address (
	input  wire bbc_pkg::crtc_addr_t crtc_i,
	input  wire [1:0]                disp_offs_i,
	output logic [`BBC_DISP_W-1:0]   disp_a_o
);

	logic [3:0] wrap;
	logic [3:0] nibble;

	// Screen start per mode, chosen by the IC32 offset bits
	always_comb begin
		case (disp_offs_i)
			2'b00: begin
				// Mode 3 restarts at 4000
				wrap = `BBC_WRAP_MODE3;
			end
			2'b01: begin
				// Mode 6 restarts at 6000
				wrap = `BBC_WRAP_MODE6;
			end
			2'b10: begin
				// Modes 0 to 2 restart at 3000
				wrap = `BBC_WRAP_MODE012;
			end
			default: begin
				// Modes 4 and 5 restart at 5800
				wrap = `BBC_WRAP_MODE45;
			end
		endcase
	end

	// MA12 flags an address past the end of RAM
	assign nibble = crtc_i.ma[12] ? (crtc_i.ma[11:8] + wrap) : crtc_i.ma[11:8];

	// Teletext reads linear bytes, graphics modes interleave the row address
	assign disp_a_o = crtc_i.ma[13] ?
		{nibble[3], 4'b1111, crtc_i.ma[9:0]} :
		{nibble, crtc_i.ma[7:0], crtc_i.ra[2:0]};

endmodule

`default_nettype wire

/* logic/bus_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bbc_cfg.svh"

module bus_mux (
	input  wire                     reset_n,
	input  wire bbc_pkg::cpu_bus_t  bus_i,
	input  wire bbc_pkg::region_e   region_i,
	input  wire bbc_pkg::model_e    model_i,
	input  wire [`BBC_DATA_W-1:0]   mem_di_i,
	input  wire bbc_pkg::periph_rd_t periph_i,
	input  wire [`BBC_DATA_W-1:0]   romsel_i,
	input  wire bbc_pkg::acccon_t   acccon_i,
	input  wire [`BBC_DISP_W-1:0]   disp_a_i,
	output logic [`BBC_DATA_W-1:0]  cpu_di_o,
	output bbc_pkg::mem_port_t      mem_o,
	output logic                    irq_n_o,
	output logic                    nmi_n_o
);
	import bbc_pkg::*;

	// CPU read data
	always_comb begin
		case (region_i)
			REG_RAM, REG_ROM, REG_MOS: cpu_di_o = mem_di_i;
			REG_CRTC:     cpu_di_o = periph_i.crtc_do;
			REG_ACIA:     cpu_di_o = `BBC_ACIA_IDLE;
			REG_SYS_VIA:  cpu_di_o = periph_i.sys_via_do;
			REG_USER_VIA: cpu_di_o = periph_i.user_via_do;
			REG_ADC:      cpu_di_o = periph_i.adc_do;
			REG_FDC:      cpu_di_o = periph_i.fdc_do;
			REG_ACCCON:   cpu_di_o = acccon_i;
			REG_ROMSEL: begin
				// Write only on the model B
				cpu_di_o = (model_i == MODEL_MASTER) ? romsel_i : '0;
			end
			// Undecoded space and drive control read as zero
			default:      cpu_di_o = '0;
		endcase
	end

	// CPU owns the memory in the PHI0 high half, video in the low half
	always_comb begin
		mem_o.adr  = bus_i.phi0 ? bus_i.addr :
			{{(`BBC_ADDR_W-`BBC_DISP_W){1'b0}}, disp_a_i};
		mem_o.we   = reset_n && !bus_i.r_nw && bus_i.phi0;
		mem_o.dout = bus_i.dout;
	end

	// Wired-OR interrupt lines, active low to the CPU
	assign irq_n_o = ~(periph_i.sys_via_irq | periph_i.user_via_irq | acccon_i.irr);
	assign nmi_n_o = ~(periph_i.fdc_irq | periph_i.fdc_drq);

endmodule

`default_nettype wire

/* logic/bbc_glue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bbc_cfg.svh"

module bbc_glue (
	input  wire                      CLK48M_I,
	input  wire                      reset_n,
	input  wire bbc_pkg::cpu_bus_t   cpu_bus_i,
	input  wire [`BBC_DATA_W-1:0]    mem_di_i,
	input  wire bbc_pkg::periph_rd_t periph_i,
	input  wire bbc_pkg::crtc_addr_t crtc_i,
	input  wire [7:0]                sys_via_pb_i,
	input  wire bbc_pkg::model_e     model_i,
	output bbc_pkg::mem_port_t       mem_o,
	output logic [`BBC_DATA_W-1:0]   cpu_di_o,
	output logic                     irq_n_o,
	output logic                     nmi_n_o,
	output logic [`BBC_DATA_W-1:0]   romsel_o,
	output bbc_pkg::ic32_t           ic32_o,
	output bbc_pkg::floppy_ctl_t     floppy_o,
	output logic                     shadow_ram_o,
	output logic                     shadow_vid_o,
	output logic                     acc_y_o
);
	import bbc_pkg::*;

	region_e                 region;
	ic32_t                   ic32;
	acccon_t                 acccon;
	logic [`BBC_DATA_W-1:0]  romsel;
	logic [`BBC_DISP_W-1:0]  disp_a;

	sheila_decode u_decode (
		.addr_i   (cpu_bus_i.addr),
		.model_i  (model_i),
		.region_o (region)
	);

	system_latches u_latches (
		.CLK48M_I     (CLK48M_I),
		.reset_n      (reset_n),
		.bus_i        (cpu_bus_i),
		.region_i     (region),
		.model_i      (model_i),
		.sys_via_pb_i (sys_via_pb_i),
		.romsel_o     (romsel),
		.ic32_o       (ic32)
	);

	master_control_regs u_master (
		.CLK48M_I     (CLK48M_I),
		.reset_n      (reset_n),
		.bus_i        (cpu_bus_i),
		.region_i     (region),
		.acccon_o     (acccon),
		.shadow_ram_o (shadow_ram_o),
		.floppy_o     (floppy_o)
	);

	screen_address u_screen (
		.crtc_i      (crtc_i),
		.disp_offs_i (ic32.disp_offs),
		.disp_a_o    (disp_a)
	);

	bus_mux u_mux (
		.reset_n  (reset_n),
		.bus_i    (cpu_bus_i),
		.region_i (region),
		.model_i  (model_i),
		.mem_di_i (mem_di_i),
		.periph_i (periph_i),
		.romsel_i (romsel),
		.acccon_i (acccon),
		.disp_a_i (disp_a),
		.cpu_di_o (cpu_di_o),
		.mem_o    (mem_o),
		.irq_n_o  (irq_n_o),
		.nmi_n_o  (nmi_n_o)
	);

	assign romsel_o     = romsel;
	assign ic32_o       = ic32;
	// Video ULA fetches from shadow RAM when D is set
	assign shadow_vid_o = acccon.d;
	assign acc_y_o      = acccon.y;

endmodule

`default_nettype wire

/* test/tb_bbc_glue.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bbc_glue;
	import bbc_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int RESET_CYCLES   = 12;
	localparam int READ_CYCLES    = 64;
	localparam int ROMSEL_CYCLES  = 12;
	localparam int IC32_CYCLES    = 40;
	localparam int ACCCON_CYCLES  = 50;
	localparam int DRIVE_CYCLES   = 60;
	localparam int DISPLAY_CYCLES = 170;
	localparam int WATCHDOG_NS    = 2 * CLK_PERIOD * (2 * RESET_CYCLES + READ_CYCLES +
		ROMSEL_CYCLES + IC32_CYCLES + ACCCON_CYCLES + DRIVE_CYCLES + DISPLAY_CYCLES);
	localparam logic [7:0] MEM_BYTE = 8'hA5;

	logic        CLK48M_I;
	logic        reset_n;
	cpu_bus_t    cpu_bus;
	logic [7:0]  mem_di;
	periph_rd_t  periph;
	crtc_addr_t  crtc;
	logic [7:0]  sys_via_pb;
	model_e      model;
	mem_port_t   mem_o;
	logic [7:0]  cpu_di_o;
	logic        irq_n_o;
	logic        nmi_n_o;
	logic [7:0]  romsel_o;
	ic32_t       ic32_o;
	floppy_ctl_t floppy_o;
	logic        shadow_ram_o;
	logic        shadow_vid_o;
	logic        acc_y_o;
	logic [31:0] rng;

	// Corners of every region plus a few undecoded SHEILA offsets
	logic [15:0] addr_list [30] = '{
		16'h0000, 16'h3ABC, 16'h7FFF, 16'h8000, 16'hBFFF, 16'hC000, 16'hFBFF, 16'hFC00,
		16'hFDFF, 16'hFF00, 16'hFFFF, 16'hFE00, 16'hFE07, 16'hFE08, 16'hFE0F, 16'hFE18,
		16'hFE1F, 16'hFE24, 16'hFE28, 16'hFE2F, 16'hFE30, 16'hFE34, 16'hFE40, 16'hFE5F,
		16'hFE60, 16'hFE7F, 16'hFEC0, 16'hFEDF, 16'hFE80, 16'hFEE0
	};

	bbc_glue u_bbc_glue (
		.CLK48M_I     (CLK48M_I),
		.reset_n      (reset_n),
		.cpu_bus_i    (cpu_bus),
		.mem_di_i     (mem_di),
		.periph_i     (periph),
		.crtc_i       (crtc),
		.sys_via_pb_i (sys_via_pb),
		.model_i      (model),
		.mem_o        (mem_o),
		.cpu_di_o     (cpu_di_o),
		.irq_n_o      (irq_n_o),
		.nmi_n_o      (nmi_n_o),
		.romsel_o     (romsel_o),
		.ic32_o       (ic32_o),
		.floppy_o     (floppy_o),
		.shadow_ram_o (shadow_ram_o),
		.shadow_vid_o (shadow_vid_o),
		.acc_y_o      (acc_y_o)
	);

	initial begin
		CLK48M_I = 1'b0;
		forever #(CLK_PERIOD / 2) CLK48M_I = ~CLK48M_I;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display(">>> FAIL");
		$fatal(1, "watchdog expired");
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Fail %s expected %h actual %h", name, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "check failed");
		end
	endtask

	// Registers still hold their reset values when this is used
	function automatic logic [7:0] expected_read(input logic [15:0] a, input logic master);
		logic [7:0] o;
		o = a[7:0];
		if (a < 16'hC000) return MEM_BYTE;
		if (a >= 16'hFC00 && a <= 16'hFDFF) return 8'h00;
		if (a[15:8] != 8'hFE) return MEM_BYTE;
		if (o <= 8'h07) return periph.crtc_do;
		if (o <= 8'h0F) return 8'h02;
		if (o >= 8'h40 && o <= 8'h5F) return periph.sys_via_do;
		if (o >= 8'h60 && o <= 8'h7F) return periph.user_via_do;
		if (master && o >= 8'h18 && o <= 8'h1F) return periph.adc_do;
		if (master && o >= 8'h28 && o <= 8'h2F) return periph.fdc_do;
		if (!master && o >= 8'hC0 && o <= 8'hDF) return periph.adc_do;
		return 8'h00;
	endfunction

	function automatic logic [14:0] translate(input logic [13:0] ma, input logic [2:0] ra,
		input logic [1:0] offs);
		logic [3:0] adj;
		logic [3:0] nib;
		case (offs)
			2'b00: adj = 4'd8;
			2'b01: adj = 4'd12;
			2'b10: adj = 4'd6;
			default: adj = 4'd11;
		endcase
		nib = ma[11:8];
		if (ma[12]) nib = nib + adj;
		if (ma[13]) return {nib[3], 4'hF, ma[9:0]};
		return {nib, ma[7:0], ra};
	endfunction

	task automatic apply_reset();
		@(posedge CLK48M_I);
		reset_n <= 1'b0;
		repeat (10) @(posedge CLK48M_I);
		reset_n <= 1'b1;
		@(negedge CLK48M_I);
	endtask

	task automatic select_model(input model_e m);
		@(posedge CLK48M_I);
		model <= m;
	endtask

	// One CPU cycle with clken high for a single capturing edge
	task automatic bus_cycle(input logic [15:0] a, input logic [7:0] d, input logic rnw,
		input logic s);
		@(posedge CLK48M_I);
		cpu_bus <= '{addr: a, dout: d, r_nw: rnw, sync: s, clken: 1'b1, phi0: 1'b1};
		@(posedge CLK48M_I);
		cpu_bus.clken <= 1'b0;
		cpu_bus.sync  <= 1'b0;
		cpu_bus.r_nw  <= 1'b1;
		@(negedge CLK48M_I);
	endtask

	// Bus values with clken low leave every register alone
	task automatic drive_bus(input logic [15:0] a, input logic [7:0] d, input logic rnw,
		input logic s, input logic p);
		@(posedge CLK48M_I);
		cpu_bus <= '{addr: a, dout: d, r_nw: rnw, sync: s, clken: 1'b0, phi0: p};
		@(negedge CLK48M_I);
	endtask

	task automatic set_latch_bit(input logic [2:0] sel, input logic v);
		@(posedge CLK48M_I);
		sys_via_pb    <= {4'h0, v, sel};
		cpu_bus.clken <= 1'b1;
		cpu_bus.r_nw  <= 1'b1;
		@(posedge CLK48M_I);
		cpu_bus.clken <= 1'b0;
		@(negedge CLK48M_I);
	endtask

	task automatic read_decode();
		for (int m = 0; m < 2; m++) begin
			select_model(m == 0 ? MODEL_MASTER : MODEL_B);
			for (int i = 0; i < 30; i++) begin
				drive_bus(addr_list[i], 8'h00, 1'b1, 1'b0, 1'b1);
				check($sformatf("read_mux %h", addr_list[i]),
					32'(expected_read(addr_list[i], m == 0)), 32'(cpu_di_o));
			end
		end
	endtask

	task automatic rom_select();
		logic [7:0] b;
		for (int m = 0; m < 2; m++) begin
			select_model(m == 0 ? MODEL_MASTER : MODEL_B);
			rng = xorshift32(rng);
			b = {1'b1, rng[6:0]};
			bus_cycle(16'hFE30, b, 1'b0, 1'b0);
			check("romsel", 32'(m == 0 ? b : {1'b0, b[6:0]}), 32'(romsel_o));
			drive_bus(16'hFE30, 8'h00, 1'b1, 1'b0, 1'b1);
			check("romsel_read", 32'(m == 0 ? b : 8'h00), 32'(cpu_di_o));
		end
	endtask

	task automatic latch_bits();
		logic [7:0] exp_ic32;
		logic [2:0] sel;
		exp_ic32 = 8'h00;
		for (int v = 1; v >= 0; v--) begin
			for (int s = 0; s < 8; s++) begin
				sel = 3'(s);
				set_latch_bit(sel, v == 1);
				exp_ic32[sel] = (v == 1);
				check("ic32", 32'(exp_ic32), 32'(ic32_o));
			end
		end
	endtask

	task automatic access_control();
		logic [15:0] a;
		select_model(MODEL_MASTER);
		bus_cycle(16'hFE34, 8'h04, 1'b0, 1'b0);
		for (int i = 0; i < 20; i++) begin
			rng = xorshift32(rng);
			a = i[0] ? rng[15:0] : 16'h3000 + 16'(rng % 32'h5000);
			drive_bus(a, 8'h00, 1'b1, 1'b0, 1'b1);
			check("shadow_x", 32'(a >= 16'h3000 && a <= 16'h7FFF), 32'(shadow_ram_o));
		end
		// With only E set the last opcode fetch decides
		bus_cycle(16'hFE34, 8'h02, 1'b0, 1'b0);
		bus_cycle(16'hC123, 8'h00, 1'b1, 1'b1);
		drive_bus(16'h4000, 8'h00, 1'b1, 1'b0, 1'b1);
		check("shadow_vdu", 32'd1, 32'(shadow_ram_o));
		drive_bus(16'h2FFF, 8'h00, 1'b1, 1'b0, 1'b1);
		check("shadow_vdu_low", 32'd0, 32'(shadow_ram_o));
		drive_bus(16'h4000, 8'h00, 1'b1, 1'b1, 1'b1);
		check("shadow_vdu_sync", 32'd0, 32'(shadow_ram_o));
		bus_cycle(16'hE000, 8'h00, 1'b1, 1'b1);
		drive_bus(16'h4000, 8'h00, 1'b1, 1'b0, 1'b1);
		check("shadow_other", 32'd0, 32'(shadow_ram_o));
		bus_cycle(16'hFE34, 8'h89, 1'b0, 1'b0);
		check("acccon_irq", 32'd0, 32'(irq_n_o));
		check("acccon_y", 32'd1, 32'(acc_y_o));
		check("acccon_d", 32'd1, 32'(shadow_vid_o));
		drive_bus(16'hFE34, 8'h00, 1'b1, 1'b0, 1'b1);
		check("acccon_read", 32'h89, 32'(cpu_di_o));
		bus_cycle(16'hFE34, 8'h00, 1'b0, 1'b0);
		check("acccon_irq_off", 32'd1, 32'(irq_n_o));
		check("acccon_y_off", 32'd0, 32'(acc_y_o));
		check("acccon_d_off", 32'd0, 32'(shadow_vid_o));
	endtask

	task automatic drive_control_irq();
		logic [7:0] d;
		// Move every register off its reset value
		bus_cycle(16'hFE24, 8'h25, 1'b0, 1'b0);
		bus_cycle(16'hFE34, 8'h8B, 1'b0, 1'b0);
		bus_cycle(16'hC000, 8'h00, 1'b1, 1'b1);
		set_latch_bit(3'd6, 1'b1);
		apply_reset();
		check("floppy_reset", 32'(7'b1111_000), 32'(floppy_o));
		check("romsel_reset", 32'd0, 32'(romsel_o));
		check("ic32_reset", 32'd0, 32'(ic32_o));
		check("irq_reset", 32'd1, 32'(irq_n_o));
		check("acccon_y_reset", 32'd0, 32'(acc_y_o));
		check("acccon_d_reset", 32'd0, 32'(shadow_vid_o));
		// VDU flag cleared, so E alone maps nothing
		bus_cycle(16'hFE34, 8'h02, 1'b0, 1'b0);
		drive_bus(16'h4000, 8'h00, 1'b1, 1'b0, 1'b1);
		check("vdu_op_reset", 32'd0, 32'(shadow_ram_o));
		for (int i = 0; i < 6; i++) begin
			rng = xorshift32(rng);
			d = rng[7:0];
			bus_cycle(16'hFE24, d, 1'b0, 1'b0);
			check("floppy", 32'({3'b111, ~d[0], ~d[4], d[2], d[5]}), 32'(floppy_o));
		end
		for (int i = 0; i < 16; i++) begin
			@(posedge CLK48M_I);
			periph.sys_via_irq  <= i[3];
			periph.user_via_irq <= i[2];
			periph.fdc_irq      <= i[1];
			periph.fdc_drq      <= i[0];
			@(negedge CLK48M_I);
			check("irq_comb", 32'(!(i[3] | i[2])), 32'(irq_n_o));
			check("nmi_comb", 32'(!(i[1] | i[0])), 32'(nmi_n_o));
		end
	endtask

	task automatic display_port();
		logic [13:0] ma;
		logic [2:0]  ra;
		logic [1:0]  offs;
		logic        rnw;
		for (int i = 0; i < 24; i++) begin
			rng = xorshift32(rng);
			ma = rng[13:0];
			ra = rng[16:14];
			offs = rng[21:20];
			rnw = rng[22];
			set_latch_bit(3'd4, offs[0]);
			set_latch_bit(3'd5, offs[1]);
			@(posedge CLK48M_I);
			crtc <= '{ma: ma, ra: {rng[24:23], ra}};
			rng = xorshift32(rng);
			cpu_bus <= '{addr: rng[15:0], dout: rng[23:16], r_nw: rnw, sync: 1'b0,
				clken: 1'b0, phi0: 1'b0};
			@(negedge CLK48M_I);
			check("video_adr", 32'({1'b0, translate(ma, ra, offs)}), 32'(mem_o.adr));
			check("video_we", 32'd0, 32'(mem_o.we));
			drive_bus(rng[15:0], rng[23:16], rnw, 1'b0, 1'b1);
			check("cpu_adr", 32'(rng[15:0]), 32'(mem_o.adr));
			check("cpu_we", 32'(!rnw), 32'(mem_o.we));
			check("cpu_dout", 32'(rng[23:16]), 32'(mem_o.dout));
		end
	endtask

	initial begin
		reset_n    = 1'b0;
		cpu_bus    = '{addr: 16'h0000, dout: 8'h00, r_nw: 1'b1, sync: 1'b0,
			clken: 1'b0, phi0: 1'b0};
		mem_di     = MEM_BYTE;
		periph     = '{crtc_do: 8'h11, sys_via_do: 8'h22, user_via_do: 8'h33,
			adc_do: 8'h44, fdc_do: 8'h55, sys_via_irq: 1'b0, user_via_irq: 1'b0,
			fdc_irq: 1'b0, fdc_drq: 1'b0};
		crtc       = '0;
		sys_via_pb = 8'h00;
		model      = MODEL_MASTER;
		rng        = 32'h9cb2_ca07;
		apply_reset();
		read_decode();
		rom_select();
		latch_bits();
		access_control();
		drive_control_irq();
		display_port();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+logic
logic/bbc_pkg.sv
logic/sheila_decode.sv
logic/system_latches.sv
logic/master_control_regs.sv
logic/screen_address.sv
logic/bus_mux.sv
logic/bbc_glue.sv
test/tb_bbc_glue.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_bbc_glue
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= >>> PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
